/* design/acc_pkg.sv */
// package with word, state, instruction union, decode enums and opcode constants
package acc_pkg;

    typedef logic [11:0] word_t;           // bit 11 is machine bit 0

    typedef struct packed {
        logic  link;
        word_t ac;
        word_t mq;
    } acc_state_s;

    // memory-reference view
    typedef struct packed {
        logic [2:0] opcode;
        logic       ind;
        logic       page;
        logic [6:0] offset;
    } mem_ref_s;

    // operate group 1 view
    typedef struct packed {
        logic [2:0] opcode;
        logic       grp;                   // 0 for group 1
        logic       cla;
        logic       cll;
        logic       cma;
        logic       cml;
        logic       rar;
        logic       ral;
        logic       rt;                    // twice or byte swap
        logic       iac;
    } op1_s;

    // operate group 3 view
    typedef struct packed {
        logic [2:0] opcode;
        logic       grp;                   // 1 for groups 2 and 3
        logic       cla;
        logic       mqa;
        logic       sca;
        logic       mql;
        logic [2:0] eae;                   // extended arithmetic code
        logic       one;                   // 1 selects group 3
    } op3_s;

    typedef union packed {
        mem_ref_s mem;
        op1_s     op1;
        op3_s     op3;
    } instr_u;

    typedef enum logic [1:0] {CLS_MEMREF, CLS_OP1, CLS_OP3, CLS_OTHER} instr_class_e;
    typedef enum logic [1:0] {EAE_NONE, EAE_MUL, EAE_DIV} eae_op_e;
    typedef enum logic [1:0] {PH_CLEAR_COMP, PH_INCR, PH_ROTATE} op1_phase_e;

    localparam logic [2:0] OPC_AND = 3'o0;
    localparam logic [2:0] OPC_TAD = 3'o1;
    localparam logic [2:0] OPC_DCA = 3'o3;
    localparam logic [2:0] OPC_OPR = 3'o7;

    localparam logic [2:0] EAE_CODE_MUL = 3'o2;   // 7405
    localparam logic [2:0] EAE_CODE_DIV = 3'o3;   // 7407

endpackage

/* design/op1_unit.sv */
// group 1 operate logic: clear and complement, increment, rotate and byte swap
module op1_unit
    import acc_pkg::*;
(
    input  op1_s       instr,
    input  op1_phase_e phase,
    input  acc_state_s cur,
    output acc_state_s next
);

    logic [12:0] lac;                      // link:ac as one 13-bit word
    logic [12:0] ror1;
    logic [12:0] ror2;
    logic [12:0] rol1;
    logic [12:0] rol2;

    assign lac  = {cur.link, cur.ac};
    assign ror1 = {lac[0], lac[12:1]};
    assign ror2 = {lac[1:0], lac[12:2]};
    assign rol1 = {lac[11:0], lac[12]};
    assign rol2 = {lac[10:0], lac[12:11]};

    always_comb
    begin
        next = cur;                        // mq passes through in every phase
        case (phase)
            PH_CLEAR_COMP:
            begin
                if (instr.cla)
                    next.ac = '0;
                if (instr.cll)
                    next.link = 1'b0;
                if (instr.cma)
                    next.ac = ~next.ac;    // after the clear
                if (instr.cml)
                    next.link = ~next.link;
            end
            PH_INCR:
            begin
                if (instr.iac)
                    {next.link, next.ac} = lac + 13'd1;  // carry toggles link
            end
            PH_ROTATE:
            begin
                case ({instr.rar, instr.ral, instr.rt})
                    3'b100: {next.link, next.ac} = ror1;  // rar
                    3'b101: {next.link, next.ac} = ror2;  // rtr
                    3'b010: {next.link, next.ac} = rol1;  // ral
                    3'b011: {next.link, next.ac} = rol2;  // rtl
                    3'b001: next.ac = {cur.ac[5:0], cur.ac[11:6]};  // bsw
                    default: next = cur;   // rar with ral is a no-op
                endcase
            end
            default: next = cur;
        endcase
    end

endmodule

/* design/mq_unit.sv */
// group 3 MQ micro-operations: MQL, MQA, SWP, CAM, ACL and CLA SWP
module mq_unit
    import acc_pkg::*;
(
    input  op3_s       instr,
    input  acc_state_s cur,
    output acc_state_s next
);

    word_t a;                              // ac after cla
    word_t m;                              // old mq

    assign a = instr.cla ? '0 : cur.ac;
    assign m = cur.mq;

    always_comb
    begin
        next = cur;                        // link untouched
        case ({instr.mqa, instr.mql})
            2'b11:                         // swp, cla swp
            begin
                next.ac = m;
                next.mq = a;
            end
            2'b10:                         // mqa, acl
            begin
                next.ac = a | m;
            end
            2'b01:                         // mql, cam
            begin
                next.mq = a;
                next.ac = '0;
            end
            default:
            begin
                next.ac = a;               // plain cla or nop
            end
        endcase
    end

endmodule

/* design/eae_muldiv.sv */
// extended arithmetic multiply and divide sequencer with step counter
module eae_muldiv
    import acc_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       go,
    input  eae_op_e    op,
    input  word_t      operand,
    input  acc_state_s cur,
    output acc_state_s next,
    output logic       last
);

    typedef enum logic [1:0] {ST_IDLE, ST_SETUP, ST_STEP} eae_fsm_e;

    eae_fsm_e    fsm_q;
    logic [3:0]  cnt_q;                    // steps left after the current one
    logic        ovf_q;
    word_t       opnd_q;                   // multiplicand or divisor
    logic        ovf;
    logic        div_ovf;
    logic [12:0] mul_sum;
    logic [13:0] div_diff;

    assign ovf      = (cur.ac >= opnd_q);
    assign div_ovf  = (op == EAE_DIV) && ovf;
    assign mul_sum  = {1'b0, cur.ac} + (cur.mq[0] ? {1'b0, opnd_q} : 13'd0);
    assign div_diff = {1'b0, cur.ac, cur.mq[11]} - {2'b00, opnd_q};
    assign last     = (fsm_q == ST_STEP) && (cnt_q == 4'd0);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            fsm_q <= ST_IDLE;
            cnt_q <= 4'd0;
            ovf_q <= 1'b0;
        end
        else
        begin
            case (fsm_q)
                ST_IDLE:
                begin
                    if (go)
                        fsm_q <= ST_SETUP;
                end
                ST_SETUP:
                begin
                    fsm_q <= ST_STEP;
                    ovf_q <= div_ovf;
                    cnt_q <= div_ovf ? 4'd0 : 4'd11;  // one step on overflow
                end
                ST_STEP:
                begin
                    if (cnt_q == 4'd0)
                        fsm_q <= ST_IDLE;
                    else
                        cnt_q <= cnt_q - 4'd1;
                end
                default: fsm_q <= ST_IDLE;
            endcase
        end
    end

    // tracks the operand while idle so the start-cycle value is held
    always_ff @(posedge clk)
    begin
        if (fsm_q == ST_IDLE && !go)
            opnd_q <= operand;
    end

    always_comb
    begin
        next = cur;
        case (fsm_q)
            ST_SETUP:
            begin
                next.link = div_ovf;       // mul always clears the link
            end
            ST_STEP:
            begin
                if (op == EAE_MUL)
                begin
                    next.ac = mul_sum[12:1];
                    next.mq = {mul_sum[0], cur.mq[11:1]};
                end
                else if (ovf_q)
                begin
                    next.mq = {cur.mq[10:0], 1'b1};
                end
                else if (!div_diff[13])    // subtract fits, quotient bit 1
                begin
                    next.ac = div_diff[11:0];
                    next.mq = {cur.mq[10:0], 1'b1};
                end
                else
                begin
                    next.ac = {cur.ac[10:0], cur.mq[11]};
                    next.mq = {cur.mq[10:0], 1'b0};
                end
            end
            default: next = cur;
        endcase
    end

endmodule

/* design/acc_datapath.sv */
// accumulator registers, class decode, phase sequencing, memory reference ops, write select
module acc_datapath
    import acc_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         start,
    input  instr_u       instr,
    input  word_t        operand,
    input  acc_state_s   op1_next,
    input  acc_state_s   mq_next,
    input  acc_state_s   eae_next,
    input  logic         eae_last,
    output acc_state_s   cur,
    output op1_phase_e   op1_phase,
    output logic         eae_go,
    output eae_op_e      eae_op,
    output logic         busy,
    output logic         done
);

    instr_u       instr_q;
    word_t        opnd_q;
    instr_class_e cls_q;
    instr_class_e cls_d;
    acc_state_s   state_q;
    acc_state_s   state_d;
    acc_state_s   mem_next;
    logic [12:0]  tad_sum;
    logic [1:0]   ph_q;
    logic         busy_q;
    logic         done_q;
    logic         accept;
    logic         exec;
    logic         fin;
    logic         eae_phase;

    assign accept    = start && !busy_q;
    assign exec      = busy_q && !done_q;  // done cycle does no work
    assign eae_phase = (cls_q == CLS_OP3) && (ph_q != 2'd0);

    always_comb
    begin
        if (instr.mem.opcode == OPC_OPR)
        begin
            if (!instr.op1.grp)
                cls_d = CLS_OP1;
            else if (instr.op3.one)
                cls_d = CLS_OP3;
            else
                cls_d = CLS_OTHER;         // group 2
        end
        else if (instr.mem.opcode == OPC_AND || instr.mem.opcode == OPC_TAD ||
                 instr.mem.opcode == OPC_DCA)
            cls_d = CLS_MEMREF;
        else
            cls_d = CLS_OTHER;
    end

    always_comb
    begin
        eae_op = EAE_NONE;
        if (cls_q == CLS_OP3)
        begin
            if (instr_q.op3.eae == EAE_CODE_MUL)
                eae_op = EAE_MUL;
            else if (instr_q.op3.eae == EAE_CODE_DIV)
                eae_op = EAE_DIV;
        end
    end

    assign tad_sum = {state_q.link, state_q.ac} + {1'b0, opnd_q};

    always_comb
    begin
        mem_next = state_q;
        case (instr_q.mem.opcode)
            OPC_AND: mem_next.ac = state_q.ac & opnd_q;
            OPC_TAD: {mem_next.link, mem_next.ac} = tad_sum;
            OPC_DCA: mem_next.ac = '0;    // the store itself is outside
            default: mem_next = state_q;
        endcase
    end

    always_comb
    begin
        fin = 1'b0;
        if (exec)
        begin
            case (cls_q)
                CLS_OP1: fin = (ph_q == 2'd2);
                CLS_OP3: fin = eae_phase ? eae_last : (eae_op == EAE_NONE);
                default: fin = 1'b1;
            endcase
        end
    end

    always_comb
    begin
        state_d = state_q;
        if (exec)
        begin
            case (cls_q)
                CLS_MEMREF: state_d = mem_next;
                CLS_OP1:    state_d = op1_next;
                CLS_OP3:    state_d = eae_phase ? eae_next : mq_next;
                default:    state_d = state_q;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_q <= '0;
            cls_q   <= CLS_OTHER;
            ph_q    <= 2'd0;
            busy_q  <= 1'b0;
            done_q  <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            done_q  <= fin;
            if (accept)
            begin
                busy_q <= 1'b1;
                cls_q  <= cls_d;
                ph_q   <= 2'd0;
            end
            else if (done_q)
                busy_q <= 1'b0;
            else if (exec && !fin && !eae_phase)
                ph_q <= ph_q + 2'd1;       // holds at 1 while the EAE steps
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            instr_q <= instr;
            opnd_q  <= operand;
        end
    end

    assign cur       = state_q;
    assign op1_phase = op1_phase_e'(ph_q);
    assign eae_go    = exec && (cls_q == CLS_OP3) && !eae_phase && (eae_op != EAE_NONE);
    assign busy      = busy_q;
    assign done      = done_q;

endmodule

/* design/acc_core.sv */
// accumulator section top level: datapath with group 1, MQ and EAE units
module acc_core
    import acc_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  instr_u     instr,
    input  word_t      operand,
    output acc_state_s state,
    output logic       busy,
    output logic       done
);

    acc_state_s cur;
    acc_state_s op1_next;
    acc_state_s mq_next;
    acc_state_s eae_next;
    op1_phase_e op1_phase;
    eae_op_e    eae_op;
    logic       eae_go;
    logic       eae_last;

    acc_datapath u_datapath (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .instr     (instr),
        .operand   (operand),
        .op1_next  (op1_next),
        .mq_next   (mq_next),
        .eae_next  (eae_next),
        .eae_last  (eae_last),
        .cur       (cur),
        .op1_phase (op1_phase),
        .eae_go    (eae_go),
        .eae_op    (eae_op),
        .busy      (busy),
        .done      (done)
    );

    op1_unit u_op1 (
        .instr (instr.op1),
        .phase (op1_phase),
        .cur   (cur),
        .next  (op1_next)
    );

    mq_unit u_mq (
        .instr (instr.op3),
        .cur   (cur),
        .next  (mq_next)
    );

    eae_muldiv u_eae (
        .clk     (clk),
        .rst_n   (rst_n),
        .go      (eae_go),
        .op      (eae_op),
        .operand (operand),
        .cur     (cur),
        .next    (eae_next),
        .last    (eae_last)
    );

    assign state = cur;

endmodule

/* tb/acc_core_props.sv */
// concurrent assertions on start, busy and done of acc_core and their bind
module acc_core_props
(
    input logic clk,
    input logic rst_n,
    input logic start,
    input logic busy,
    input logic done
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    done_single: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
    else
    begin
        $error("done stayed high for more than one cycle");
        fail_count++;
    end

    done_in_busy: assert property (@(posedge clk) disable iff (!rst_n) done |-> busy)
    else
    begin
        $error("done was high while busy was low");
        fail_count++;
    end

    // first sampled cycle out of reset
    idle_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !busy && !done)
    else
    begin
        $error("busy or done high in the first cycle after reset");
        fail_count++;
    end

    busy_falls: assert property (@(posedge clk) disable iff (!rst_n) done |=> !busy)
    else
    begin
        $error("busy still high in the cycle after done");
        fail_count++;
    end

    start_taken: assert property (@(posedge clk) disable iff (!rst_n) start && !busy |=> busy)
    else
    begin
        $error("start while idle did not raise busy");
        fail_count++;
    end

endmodule

bind acc_core acc_core_props u_props (
    .clk   (clk),
    .rst_n (rst_n),
    .start (start),
    .busy  (busy),
    .done  (done)
);

/* tb/acc_core_tb.sv */
// testbench top with clock, reset, vector tests, random multiply and divide, busy start and watchdog
module acc_core_tb
    import acc_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD       = 100;
    localparam int RESET_CYCLES     = 2;
    localparam int MAX_VECTORS      = 40;
    localparam int N_MUL            = 8;
    localparam int N_DIV            = 8;
    localparam int N_OVF            = 4;
    localparam int CYCLES_PER_INSTR = 20;
    // random tests issue four loads ahead of the multiply or divide
    localparam int INSTR_BUDGET     = MAX_VECTORS + 5 * (N_MUL + N_DIV + N_OVF + 1);
    localparam int WATCHDOG_CYCLES  = RESET_CYCLES + 1 + CYCLES_PER_INSTR * INSTR_BUDGET;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        start;
    instr_u      instr;
    word_t       operand;
    acc_state_s  state;
    logic        busy;
    logic        done;

    logic [31:0] rng;
    int          check_errors;
    int          n_tests;
    int          n_pass;
    int          n_fail;
    int          done_seen;

    acc_core DUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .instr   (instr),
        .operand (operand),
        .state   (state),
        .busy    (busy),
        .done    (done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(negedge clk)
    begin
        if (done === 1'b1)
            done_seen++;                   // one count per pulse
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t rand_word();
        rng = xorshift(rng);
        return rng[23:12];
    endfunction

    task automatic compare_word(input string name, input string field, input word_t exp,
                                input word_t act);
        if (act !== exp)
        begin
            $display("Fail %s %s: expected %04o, actual %04o", name, field, exp, act);
            check_errors++;
        end
    endtask

    task automatic compare_link(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("Fail %s link: expected %b, actual %b", name, exp, act);
            check_errors++;
        end
    endtask

    task automatic check_state(input string name, input logic exp_link, input word_t exp_ac,
                               input word_t exp_mq);
        compare_link(name, exp_link, state.link);
        compare_word(name, "ac", exp_ac, state.ac);
        compare_word(name, "mq", exp_mq, state.mq);
    endtask

    task automatic end_test(input string name, input int mark);
        n_tests++;
        if (check_errors == mark)
        begin
            n_pass++;
            $display("%-14s ok", name);
        end
        else
        begin
            n_fail++;
            $display("%-14s failed", name);
        end
    endtask

    // instr and operand stay on the ports until the next instruction
    task automatic run_instr(input word_t code, input word_t opnd);
        @(negedge clk);
        instr   = code;
        operand = opnd;
        start   = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (done !== 1'b1)
            @(negedge clk);
    endtask

    task automatic load_regs(input word_t a, input word_t m);
        run_instr(12'o7300, '0);           // cla cll
        run_instr(12'o1000, m);            // tad
        run_instr(12'o7421, '0);           // mql
        run_instr(12'o1000, a);
    endtask

    task automatic run_vectors();
        int    fd;
        int    mark;
        string line;
        string name;
        word_t code;
        word_t opnd;
        logic  exp_link;
        word_t exp_ac;
        word_t exp_mq;
        fd = $fopen("tb/acc_core_vectors.txt", "r");
        if (fd == 0)
        begin
            mark = check_errors;
            $display("the vector file tb/acc_core_vectors.txt could not be opened");
            check_errors++;
            end_test("vector_file", mark);
            return;
        end
        while ($fgets(line, fd) != 0)
        begin
            if (line.len() < 2 || line[0] == "#")
                continue;                  // comment or blank line
            mark = check_errors;
            if ($sscanf(line, "%s %o %o %o %o %o", name, code, opnd,
                        exp_link, exp_ac, exp_mq) != 6)
            begin
                $display("a vector line could not be read: %s", line);
                check_errors++;
                end_test("vector_line", mark);
                continue;
            end
            run_instr(code, opnd);
            check_state(name, exp_link, exp_ac, exp_mq);
            end_test(name, mark);
        end
        $fclose(fd);
    endtask

    task automatic random_mul(input int idx);
        word_t       a;
        word_t       m;
        word_t       d;
        logic [23:0] prod;
        int          mark;
        string       name;
        a    = rand_word();
        m    = rand_word();
        d    = rand_word();
        prod = {12'd0, m} * {12'd0, d} + {12'd0, a};  // ac:mq = mq * operand + ac
        name = $sformatf("mul_%0d", idx);
        load_regs(a, m);
        mark = check_errors;
        run_instr(12'o7405, d);
        check_state(name, 1'b0, prod[23:12], prod[11:0]);
        end_test(name, mark);
    endtask

    task automatic random_div(input int idx, input logic want_ovf);
        word_t       a;
        word_t       m;
        word_t       d;
        logic [23:0] dividend;
        logic [23:0] quot;
        logic [23:0] rem;
        int          span;
        int          tmp;
        int          mark;
        string       name;
        m = rand_word();
        if (want_ovf)
        begin
            a    = rand_word();
            span = int'(a) + 1;
            tmp  = int'(rand_word()) % span;  // divisor not above ac
            d    = tmp[11:0];
        end
        else
        begin
            d = rand_word();
            if (d == '0)
                d = 12'd1;
            a = rand_word() % d;           // quotient fits in 12 bits
        end
        dividend = {a, m};
        quot     = dividend / d;
        rem      = dividend % d;
        name     = $sformatf("%s_%0d", want_ovf ? "ovf" : "div", idx);
        load_regs(a, m);
        mark = check_errors;
        run_instr(12'o7407, d);
        if (want_ovf)
            check_state(name, 1'b1, a, {m[10:0], 1'b1});
        else
            check_state(name, 1'b0, rem[11:0], quot[11:0]);
        end_test(name, mark);
    endtask

    // a second start in the middle of a multiply must be dropped
    task automatic busy_start_test();
        word_t       a;
        word_t       m;
        word_t       d;
        logic [23:0] prod;
        int          done_before;
        int          mark;
        a    = rand_word();
        m    = rand_word();
        d    = rand_word();
        prod = {12'd0, m} * {12'd0, d} + {12'd0, a};
        load_regs(a, m);
        mark = check_errors;
        @(negedge clk);
        done_before = done_seen;
        instr       = 12'o7405;
        operand     = d;
        start       = 1'b1;
        @(negedge clk);
        start = 1'b0;
        repeat (3) @(negedge clk);
        if (busy !== 1'b1)
        begin
            $display("busy_start: busy was low in the middle of the multiply");
            check_errors++;
        end
        instr = 12'o7200;                  // would clear ac if taken
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        instr = 12'o7405;
        while (done !== 1'b1)
            @(negedge clk);
        check_state("busy_start", 1'b0, prod[23:12], prod[11:0]);
        repeat (4) @(negedge clk);
        check_state("busy_start", 1'b0, prod[23:12], prod[11:0]);
        if (done_seen - done_before != 1)
        begin
            $display("busy_start: done was seen %0d times instead of once",
                     done_seen - done_before);
            check_errors++;
        end
        end_test("busy_start", mark);
    endtask

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    initial
    begin
        int mark;
        int prop_fails;
        rng          = 32'h421e_772c;
        check_errors = 0;
        n_tests      = 0;
        n_pass       = 0;
        n_fail       = 0;
        done_seen    = 0;
        rst_n        = 1'b0;
        start        = 1'b0;
        instr        = '0;
        operand      = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        mark  = check_errors;
        check_state("reset", 1'b0, '0, '0);
        end_test("reset", mark);
        run_vectors();
        for (int i = 0; i < N_MUL; i++)
            random_mul(i);
        for (int i = 0; i < N_DIV; i++)
            random_div(i, 1'b0);
        for (int i = 0; i < N_OVF; i++)
            random_div(i, 1'b1);
        busy_start_test();
        prop_fails = DUT.u_props.fail_count;
        $display("%0d tests, %0d passed, %0d failed, %0d assertion failures",
                 n_tests, n_pass, n_fail, prop_fails);
        if (n_fail == 0 && prop_fails == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

/* acc_core.f */
design/acc_pkg.sv
design/op1_unit.sv
design/mq_unit.sv
design/eae_muldiv.sv
design/acc_datapath.sv
design/acc_core.sv
tb/acc_core_props.sv
tb/acc_core_tb.sv

/* tb/acc_core_vectors.txt */
# name instr operand link ac mq, all numbers in octal
# state carries over from one line to the next
tad_load      1000 1234 0 1234 0000
tad_carry     1000 7000 1 0234 0000
and_mask      0000 0077 1 0034 0000
dca_clear     3000 0000 1 0000 0000
tad_prep      1000 5555 1 5555 0000
cla_cll       7300 0000 0 0000 0000
cma_cml       7060 0000 1 7777 0000
cll_iac       7101 0000 1 0000 0000
cla_cll_iac   7301 0000 0 0001 0000
iac_ral       7005 0000 0 0004 0000
tad_4000      1000 4000 0 4004 0000
ral           7004 0000 1 0010 0000
rtr           7012 0000 0 2002 0000
bsw           7002 0000 0 0220 0000
rar_ral_nop   7014 0000 0 0220 0000
rtl           7006 0000 0 1100 0000
mql           7421 0000 0 0000 1100
tad_0707      1000 0707 0 0707 1100
mqa           7501 0000 0 1707 1100
swp           7521 0000 0 1100 1707
acl           7701 0000 0 1707 1707
tad_0071      1000 0071 0 2000 1707
cam           7621 0000 0 0000 0000
tad_0456      1000 0456 0 0456 0000
mql_0456      7421 0000 0 0000 0456
tad_0321      1000 0321 0 0321 0456
cla_swp       7721 0000 0 0456 0000
hlt_other     7402 0000 0 0456 0000
mul_ac_only   7405 0003 0 0000 0456
div_small     7407 0003 0 0002 0144
